//--- Bender.yml
package:
  name: pipeline_unit

sources:
  - rv_pkg.sv
  - ir_dec_ctrl.sv
  - registers.sv
  - alu.sv
  - branch.sv
  - hazard.sv
  - pipeline_unit.sv
  - target: test
    files:
      - tb_pipeline_unit.sv

//--- alu.sv
`timescale 1ns/10ps

module alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, lt_s};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, lt_u};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        result = word_t'($signed(a) >>> shamt);
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      // lui
      default: begin
        result = b;
      end
    endcase
  end

endmodule

//--- branch.sv
`timescale 1ns/10ps

module branch (
  input  rv_pkg::func3_t func3,
  input  rv_pkg::word_t  opr1,
  input  rv_pkg::word_t  opr2,
  output logic           taken
);
  import rv_pkg::*;

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = opr1 == opr2;
  assign lt_s = $signed(opr1) < $signed(opr2);
  assign lt_u = opr1 < opr2;

  always_comb begin
    case (func3)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt_s;
      f3_bge:  taken = !lt_s;
      f3_bltu: taken = lt_u;
      f3_bgeu: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

endmodule

//--- hazard.sv
`timescale 1ns/10ps

module hazard (
  input  rv_pkg::reg_idx_t rs1_e,
  input  rv_pkg::reg_idx_t rs2_e,
  input  rv_pkg::reg_idx_t rs1_d,
  input  rv_pkg::reg_idx_t rs2_d,
  input  rv_pkg::reg_idx_t rd_e,
  input  rv_pkg::reg_idx_t rd_m,
  input  rv_pkg::reg_idx_t rd_w,
  input  logic             we_m,
  input  logic             we_w,
  input  logic             load_e,
  input  logic             use1_d,
  input  logic             use2_d,
  output rv_pkg::fwd_sel_e sel1,
  output rv_pkg::fwd_sel_e sel2,
  output logic             load_use
);
  import rv_pkg::*;

  logic hit1_d;
  logic hit2_d;

  // Youngest producer wins
  function automatic fwd_sel_e source(reg_idx_t rs);
    if (rs == '0) begin
      return fwd_raw;
    end
    if (we_m && rd_m == rs) begin
      return fwd_mem;
    end
    if (we_w && rd_w == rs) begin
      return fwd_wb;
    end
    return fwd_raw;
  endfunction

  assign sel1 = source(rs1_e);
  assign sel2 = source(rs2_e);

  // Load data only exists from write-back on, so hold decode one cycle
  assign hit1_d   = use1_d && (rs1_d == rd_e);
  assign hit2_d   = use2_d && (rs2_d == rd_e);
  assign load_use = load_e && (rd_e != '0) && (hit1_d || hit2_d);

endmodule

//--- ir_dec_ctrl.sv
`timescale 1ns/10ps

module ir_dec_ctrl (
  input  rv_pkg::word_t    ir,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output rv_pkg::func3_t   func3,
  output rv_pkg::alu_op_e  alu_op,
  output rv_pkg::a_src_e   a_src,
  output logic             b_imm,
  output logic             reg_we,
  output logic             is_load,
  output logic             is_store,
  output logic             is_branch,
  output logic             is_jal,
  output logic             is_jalr,
  output logic             uses_rs1,
  output logic             uses_rs2
);
  import rv_pkg::*;

  opcode_t opcode;
  word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_e int_op;

  assign opcode = ir[6:0];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];
  assign rd     = ir[11:7];
  assign func3  = ir[14:12];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  // Bit 30 picks sub only in the register form, sra in both
  always_comb begin
    case (func3)
      f3_add:  int_op = (opcode == op_reg && ir[30]) ? alu_sub : alu_add;
      f3_sll:  int_op = alu_sll;
      f3_slt:  int_op = alu_slt;
      f3_sltu: int_op = alu_sltu;
      f3_xor:  int_op = alu_xor;
      f3_sr:   int_op = ir[30] ? alu_sra : alu_srl;
      f3_or:   int_op = alu_or;
      default: int_op = alu_and;
    endcase
  end

  always_comb begin
    imm       = '0;
    alu_op    = alu_add;
    a_src     = a_reg;
    b_imm     = 1'b0;
    reg_we    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    case (opcode)
      op_lui: begin
        imm    = imm_u;
        alu_op = alu_pass_b;
        a_src  = a_zero;
        b_imm  = 1'b1;
        reg_we = 1'b1;
      end
      op_auipc: begin
        imm    = imm_u;
        a_src  = a_pc;
        b_imm  = 1'b1;
        reg_we = 1'b1;
      end
      op_jal: begin
        imm    = imm_j;
        reg_we = 1'b1;
        is_jal = 1'b1;
      end
      op_jalr: begin
        imm      = imm_i;
        reg_we   = 1'b1;
        is_jalr  = 1'b1;
        uses_rs1 = 1'b1;
      end
      op_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
      end
      op_load: begin
        imm      = imm_i;
        b_imm    = 1'b1;
        reg_we   = 1'b1;
        is_load  = 1'b1;
        uses_rs1 = 1'b1;
      end
      op_store: begin
        imm      = imm_s;
        b_imm    = 1'b1;
        is_store = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      op_imm: begin
        imm      = imm_i;
        alu_op   = int_op;
        b_imm    = 1'b1;
        reg_we   = 1'b1;
        uses_rs1 = 1'b1;
      end
      op_reg: begin
        alu_op   = int_op;
        reg_we   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      default: begin
        // Unknown opcode runs as a bubble
        imm = '0;
      end
    endcase
  end

endmodule

//--- pipeline_unit.sv
`timescale 1ns/10ps

module pipeline_unit (
  input  logic          clk,
  input  logic          arst_n,
  input  rv_pkg::word_t instr,
  input  rv_pkg::word_t data_mem,
  output rv_pkg::word_t pc_addr,
  output logic          mem_we,
  output logic          mem_re,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata
);
  import rv_pkg::*;

  // Fetch and decode
  word_t pc_f, pc_d, instr_d;
  reg_idx_t rs1_d, rs2_d, rd_d;
  word_t imm_d, r1_d, r2_d;
  func3_t func3_d;
  alu_op_e alu_fn_d;
  a_src_e a_sel_d;
  logic b_imm_d, reg_we_d, is_load_d, is_store_d, is_branch_d, is_jal_d, is_jalr_d;
  logic use1_d, use2_d;

  // Execute
  word_t pc_e, r1_e, r2_e, imm_e;
  func3_t func3_e;
  reg_idx_t rs1_e, rs2_e, rd_e;
  alu_op_e alu_fn_e;
  a_src_e a_sel_e;
  logic b_imm_e, reg_we_e, is_load_e, is_store_e, is_branch_e, is_jal_e, is_jalr_e;
  fwd_sel_e sel1, sel2;
  word_t opr1, opr2, alu_a, alu_b, alu_res;
  word_t jalr_sum, target_e, link_e;
  logic taken, redirect, load_use;

  // Memory
  word_t alu_m, wdata_m, link_m, fwd_m;
  reg_idx_t rd_m;
  logic reg_we_m, is_load_m, is_store_m, jump_m;

  // Write-back
  word_t alu_w, link_w, wb_data;
  reg_idx_t rd_w;
  logic reg_we_w, is_load_w, jump_w;

  function automatic word_t pick(fwd_sel_e sel, word_t raw, word_t from_m, word_t from_w);
    case (sel)
      fwd_mem: return from_m;
      fwd_wb:  return from_w;
      default: return raw;
    endcase
  endfunction

  assign pc_addr = pc_f;

  // A redirect wins over a stall and replaces the fetched word with a bubble
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_f    <= '0;
      instr_d <= nop_instr;
    end else if (redirect) begin
      pc_f    <= target_e;
      instr_d <= nop_instr;
    end else if (!load_use) begin
      pc_f    <= pc_f + 32'd4;
      instr_d <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (redirect || !load_use) begin
      pc_d <= pc_f;
    end
  end

  ir_dec_ctrl ir_dec_ctrl_i (
    .ir       (instr_d),
    .rs1      (rs1_d),
    .rs2      (rs2_d),
    .rd       (rd_d),
    .imm      (imm_d),
    .func3    (func3_d),
    .alu_op   (alu_fn_d),
    .a_src    (a_sel_d),
    .b_imm    (b_imm_d),
    .reg_we   (reg_we_d),
    .is_load  (is_load_d),
    .is_store (is_store_d),
    .is_branch(is_branch_d),
    .is_jal   (is_jal_d),
    .is_jalr  (is_jalr_d),
    .uses_rs1 (use1_d),
    .uses_rs2 (use2_d)
  );

  registers registers_i (
    .clk   (clk),
    .arst_n(arst_n),
    .we    (reg_we_w),
    .rs1   (rs1_d),
    .rs2   (rs2_d),
    .rd    (rd_w),
    .wdata (wb_data),
    .rdata1(r1_d),
    .rdata2(r2_d)
  );

  // Execute control, cleared by a flush or a load-use bubble
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_we_e    <= 1'b0;
      is_load_e   <= 1'b0;
      is_store_e  <= 1'b0;
      is_branch_e <= 1'b0;
      is_jal_e    <= 1'b0;
      is_jalr_e   <= 1'b0;
    end else if (redirect || load_use) begin
      reg_we_e    <= 1'b0;
      is_load_e   <= 1'b0;
      is_store_e  <= 1'b0;
      is_branch_e <= 1'b0;
      is_jal_e    <= 1'b0;
      is_jalr_e   <= 1'b0;
    end else begin
      reg_we_e    <= reg_we_d;
      is_load_e   <= is_load_d;
      is_store_e  <= is_store_d;
      is_branch_e <= is_branch_d;
      is_jal_e    <= is_jal_d;
      is_jalr_e   <= is_jalr_d;
    end
  end

  always_ff @(posedge clk) begin
    pc_e     <= pc_d;
    r1_e     <= r1_d;
    r2_e     <= r2_d;
    imm_e    <= imm_d;
    func3_e  <= func3_d;
    rs1_e    <= rs1_d;
    rs2_e    <= rs2_d;
    rd_e     <= rd_d;
    alu_fn_e <= alu_fn_d;
    a_sel_e  <= a_sel_d;
    b_imm_e  <= b_imm_d;
  end

  hazard hazard_i (
    .rs1_e   (rs1_e),
    .rs2_e   (rs2_e),
    .rs1_d   (rs1_d),
    .rs2_d   (rs2_d),
    .rd_e    (rd_e),
    .rd_m    (rd_m),
    .rd_w    (rd_w),
    .we_m    (reg_we_m),
    .we_w    (reg_we_w),
    .load_e  (is_load_e),
    .use1_d  (use1_d),
    .use2_d  (use2_d),
    .sel1    (sel1),
    .sel2    (sel2),
    .load_use(load_use)
  );

  assign opr1 = pick(sel1, r1_e, fwd_m, wb_data);
  assign opr2 = pick(sel2, r2_e, fwd_m, wb_data);

  always_comb begin
    case (a_sel_e)
      a_pc:    alu_a = pc_e;
      a_zero:  alu_a = '0;
      default: alu_a = opr1;
    endcase
  end

  assign alu_b = b_imm_e ? imm_e : opr2;

  alu alu_i (
    .op    (alu_fn_e),
    .a     (alu_a),
    .b     (alu_b),
    .result(alu_res)
  );

  branch branch_i (
    .func3(func3_e),
    .opr1 (opr1),
    .opr2 (opr2),
    .taken(taken)
  );

  assign jalr_sum = opr1 + imm_e;
  assign target_e = is_jalr_e ? {jalr_sum[xlen-1:1], 1'b0} : pc_e + imm_e;
  assign link_e   = pc_e + 32'd4;
  assign redirect = is_jal_e | is_jalr_e | (is_branch_e & taken);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_we_m   <= 1'b0;
      is_load_m  <= 1'b0;
      is_store_m <= 1'b0;
      jump_m     <= 1'b0;
      reg_we_w   <= 1'b0;
      is_load_w  <= 1'b0;
      jump_w     <= 1'b0;
    end else begin
      reg_we_m   <= reg_we_e;
      is_load_m  <= is_load_e;
      is_store_m <= is_store_e;
      jump_m     <= is_jal_e | is_jalr_e;
      reg_we_w   <= reg_we_m;
      is_load_w  <= is_load_m;
      jump_w     <= jump_m;
    end
  end

  always_ff @(posedge clk) begin
    alu_m   <= alu_res;
    wdata_m <= opr2;
    link_m  <= link_e;
    rd_m    <= rd_e;
    alu_w   <= alu_m;
    link_w  <= link_m;
    rd_w    <= rd_m;
  end

  assign mem_we    = is_store_m;
  assign mem_re    = is_load_m;
  assign mem_addr  = alu_m;
  assign mem_wdata = wdata_m;

  // Link value must also be visible to the memory-stage forward path
  assign fwd_m   = jump_m ? link_m : alu_m;
  assign wb_data = jump_w ? link_w : (is_load_w ? data_mem : alu_w);

endmodule

//--- registers.sv
`timescale 1ns/10ps

module registers (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             we,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    wdata,
  output rv_pkg::word_t    rdata1,
  output rv_pkg::word_t    rdata2
);
  import rv_pkg::*;

  word_t regs [reg_count];
  logic  wr_ok;

  // x0 is never written, so it reads back as zero
  assign wr_ok = we && (rd != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[rd] <= wdata;
    end
  end

  // Write-back value bypasses the array in the same cycle
  assign rdata1 = (wr_ok && rd == rs1) ? wdata : regs[rs1];
  assign rdata2 = (wr_ok && rd == rs2) ? wdata : regs[rs2];

endmodule

//--- rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] func3_t;
  typedef logic [6:0] opcode_t;

  // Base opcodes
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;

  // Branch conditions
  localparam func3_t f3_beq  = 3'b000;
  localparam func3_t f3_bne  = 3'b001;
  localparam func3_t f3_blt  = 3'b100;
  localparam func3_t f3_bge  = 3'b101;
  localparam func3_t f3_bltu = 3'b110;
  localparam func3_t f3_bgeu = 3'b111;

  // Integer op funct3
  localparam func3_t f3_add  = 3'b000;
  localparam func3_t f3_sll  = 3'b001;
  localparam func3_t f3_slt  = 3'b010;
  localparam func3_t f3_sltu = 3'b011;
  localparam func3_t f3_xor  = 3'b100;
  localparam func3_t f3_sr   = 3'b101;
  localparam func3_t f3_or   = 3'b110;
  localparam func3_t f3_and  = 3'b111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {fwd_raw, fwd_mem, fwd_wb} fwd_sel_e;

  typedef enum logic [1:0] {a_reg, a_pc, a_zero} a_src_e;

  // addi x0, x0, 0
  localparam word_t nop_instr = 32'h0000_0013;

endpackage

//--- tb.f
rv_pkg.sv
ir_dec_ctrl.sv
registers.sv
alu.sv
branch.sv
hazard.sv
pipeline_unit.sv
tb_pipeline_unit.sv

//--- tb_pipeline_unit.sv
`timescale 1ns/10ps

module tb_pipeline_unit;
  import rv_pkg::*;

  localparam logic [6:0] opc_imm   = 7'b0010011;
  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_lui   = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jalr  = 7'b1100111;
  localparam word_t result_base = 32'h100;
  localparam word_t finish_addr = 32'h3fc;
  localparam int    max_cycles  = 2000;

  logic   clk;
  logic   arst_n;
  word_t  instr;
  word_t  data_mem;
  word_t  pc_addr;
  logic   mem_we;
  logic   mem_re;
  word_t  mem_addr;
  word_t  mem_wdata;

  word_t  imem [256];
  word_t  dmem [256];
  word_t  rd_word;
  logic   done;
  int     wr_pos;
  int     errors;
  int     checks;
  integer seed;

  pipeline_unit pipeline_unit_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .instr    (instr),
    .data_mem (data_mem),
    .pc_addr  (pc_addr),
    .mem_we   (mem_we),
    .mem_re   (mem_re),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata)
  );

  always #5 clk = ~clk;

  // Data memory answers a load in the cycle after its memory stage
  always @(posedge clk) begin
    if (mem_we) begin
      dmem[mem_addr[9:2]] = mem_wdata;
      if (mem_addr == finish_addr) begin
        done = 1'b1;
      end
    end
    if (mem_re) begin
      rd_word = dmem[mem_addr[9:2]];
    end
    #1;
    instr    = imem[pc_addr[9:2]];
    data_mem = rd_word;
  end

  function automatic word_t fill_word(word_t addr);
    return (addr * 32'h0001_0003) ^ 32'h6c8e_9cf5;
  endfunction

  function automatic word_t slot_addr(int slot);
    return result_base + word_t'(4 * slot);
  endfunction

  function automatic word_t rtype(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t itype(logic [11:0] imm, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t stype(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t btype(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                  logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t jtype(reg_idx_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t utype(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // Register form of ALU op k, x10 = x1 op x2
  function automatic word_t alu_instr(int k);
    case (k)
      0:       return rtype(7'h00, 3'b000, 5'd10, 5'd1, 5'd2);
      1:       return rtype(7'h20, 3'b000, 5'd10, 5'd1, 5'd2);
      2:       return rtype(7'h00, 3'b001, 5'd10, 5'd1, 5'd2);
      3:       return rtype(7'h00, 3'b010, 5'd10, 5'd1, 5'd2);
      4:       return rtype(7'h00, 3'b011, 5'd10, 5'd1, 5'd2);
      5:       return rtype(7'h00, 3'b100, 5'd10, 5'd1, 5'd2);
      6:       return rtype(7'h00, 3'b101, 5'd10, 5'd1, 5'd2);
      7:       return rtype(7'h20, 3'b101, 5'd10, 5'd1, 5'd2);
      8:       return rtype(7'h00, 3'b110, 5'd10, 5'd1, 5'd2);
      default: return rtype(7'h00, 3'b111, 5'd10, 5'd1, 5'd2);
    endcase
  endfunction

  function automatic word_t alu_model(int k, word_t a, word_t b);
    case (k)
      0:       return a + b;
      1:       return a - b;
      2:       return a << b[4:0];
      3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4:       return (a < b) ? 32'd1 : 32'd0;
      5:       return a ^ b;
      6:       return a >> b[4:0];
      7:       return word_t'($signed(a) >>> b[4:0]);
      8:       return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_outcome(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic put(word_t w);
    imem[wr_pos] = w;
    wr_pos++;
  endtask

  task automatic pad_to(word_t byte_addr);
    while (word_t'(wr_pos * 4) < byte_addr) begin
      put(nop_instr);
    end
  endtask

  task automatic load_imm(reg_idx_t rd, word_t v);
    word_t upper;
    upper = (v + 32'h800) >> 12;
    put(utype(upper[19:0], rd, opc_lui));
    put(itype(v[11:0], 3'b000, rd, rd, opc_imm));
  endtask

  task automatic save(reg_idx_t rs, int slot);
    word_t addr;
    addr = slot_addr(slot);
    put(stype(rs, 5'd0, addr[11:0]));
  endtask

  // Reset goes low first so nothing stores while the memories are rebuilt
  task automatic new_program();
    @(posedge clk);
    #1;
    arst_n = 1'b0;
    done   = 1'b0;
    wr_pos = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = nop_instr;
      dmem[i] = fill_word(word_t'(i * 4));
    end
  endtask

  task automatic run_program(string name);
    int cycles;
    put(stype(5'd0, 5'd0, finish_addr[11:0]));
    repeat (10) @(posedge clk);
    #1;
    checks++;
    if (pc_addr !== 32'd0 || mem_we !== 1'b0 || mem_re !== 1'b0) begin
      errors++;
      $display("Error: %s reset state expected pc 0 we 0 re 0, actual pc %h we %b re %b",
               name, pc_addr, mem_we, mem_re);
    end
    arst_n = 1'b1;
    cycles = 0;
    while (!done && cycles < max_cycles) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!done) begin
      errors++;
      $display("%s: program never reached its finish store in %0d cycles", name, max_cycles);
    end
    // Jump targets keep the fetch address word aligned
    checks++;
    if (pc_addr[1:0] !== 2'b00) begin
      errors++;
      $display("Error: %s fetch address low bits expected 00 actual %b", name, pc_addr[1:0]);
    end
  endtask

  task automatic expect_word(string name, int slot, word_t exp);
    word_t addr;
    word_t got;
    addr = slot_addr(slot);
    got  = dmem[addr[9:2]];
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s slot %0d expected %h actual %h", name, slot, exp, got);
    end
  endtask

  task automatic forwarding_test();
    word_t v1, v2, v3, v4, v5, v6, v7, v8;
    new_program();
    put(itype(12'd7, 3'b000, 5'd1, 5'd0, opc_imm));
    put(itype(12'd3, 3'b000, 5'd2, 5'd1, opc_imm));
    put(rtype(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
    put(rtype(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));
    put(itype(12'hfff, 3'b100, 5'd5, 5'd4, opc_imm));
    put(itype(12'd4, 3'b001, 5'd6, 5'd3, opc_imm));
    // srai x7, x5, 1
    put(itype(12'h401, 3'b101, 5'd7, 5'd5, opc_imm));
    put(rtype(7'h00, 3'b110, 5'd8, 5'd7, 5'd6));
    save(5'd8, 6);
    for (int r = 2; r < 8; r++) begin
      save(reg_idx_t'(r), r - 2);
    end
    run_program("forwarding");
    v1 = 32'd7;
    v2 = v1 + 32'd3;
    v3 = v2 + v1;
    v4 = v3 - v2;
    v5 = v4 ^ 32'hffff_ffff;
    v6 = v3 << 4;
    v7 = word_t'($signed(v5) >>> 1);
    v8 = v7 | v6;
    expect_word("forwarding", 0, v2);
    expect_word("forwarding", 1, v3);
    expect_word("forwarding", 2, v4);
    expect_word("forwarding", 3, v5);
    expect_word("forwarding", 4, v6);
    expect_word("forwarding", 5, v7);
    expect_word("forwarding", 6, v8);
  endtask

  task automatic load_use_test();
    new_program();
    put(itype(12'd100, 3'b000, 5'd4, 5'd0, opc_imm));
    put(itype(12'h040, 3'b010, 5'd2, 5'd0, opc_load));
    put(rtype(7'h00, 3'b000, 5'd3, 5'd2, 5'd4));
    save(5'd3, 0);
    // Loaded word goes straight out as store data
    put(itype(12'h044, 3'b010, 5'd5, 5'd0, opc_load));
    save(5'd5, 1);
    put(itype(12'h048, 3'b000, 5'd6, 5'd0, opc_imm));
    put(itype(12'd4, 3'b010, 5'd7, 5'd6, opc_load));
    put(itype(12'd1, 3'b000, 5'd8, 5'd7, opc_imm));
    save(5'd8, 2);
    run_program("load_use");
    expect_word("load_use", 0, fill_word(32'h40) + 32'd100);
    expect_word("load_use", 1, fill_word(32'h44));
    expect_word("load_use", 2, fill_word(32'h4c) + 32'd1);
  endtask

  task automatic branches_test();
    logic [2:0] f3;
    reg_idx_t ra;
    reg_idx_t rb;
    word_t va;
    word_t vb;
    int k;
    string name;
    new_program();
    load_imm(5'd1, 32'hffff_fffd);
    put(itype(12'd5, 3'b000, 5'd2, 5'd0, opc_imm));
    put(itype(12'd5, 3'b000, 5'd3, 5'd0, opc_imm));
    put(itype(12'h05a, 3'b000, 5'd20, 5'd0, opc_imm));
    put(itype(12'h0a5, 3'b000, 5'd21, 5'd0, opc_imm));
    // Operand pairs (x1,x2) (x2,x1) (x2,x3) for every condition
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        k  = c * 3 + p;
        f3 = (c < 2) ? 3'(c) : 3'(c + 2);
        ra = (p == 0) ? 5'd1 : 5'd2;
        rb = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
        put(btype(f3, ra, rb, 13'd12));
        save(5'd20, 2 * k);
        put(jtype(5'd0, 21'd8));
        save(5'd21, 2 * k + 1);
      end
    end
    run_program("branches");
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        k    = c * 3 + p;
        f3   = (c < 2) ? 3'(c) : 3'(c + 2);
        va   = (p == 0) ? 32'hffff_fffd : 32'd5;
        vb   = (p == 1) ? 32'hffff_fffd : 32'd5;
        name = $sformatf("branch f3=%0d pair %0d", f3, p);
        if (branch_outcome(f3, va, vb)) begin
          expect_word(name, 2 * k, fill_word(slot_addr(2 * k)));
          expect_word(name, 2 * k + 1, 32'h0a5);
        end else begin
          expect_word(name, 2 * k, 32'h05a);
          expect_word(name, 2 * k + 1, fill_word(slot_addr(2 * k + 1)));
        end
      end
    end
  endtask

  task automatic jumps_test();
    word_t pc_auipc;
    word_t pc_jal;
    word_t pc_jalr;
    word_t jalr_target;
    new_program();
    put(utype(20'h12345, 5'd1, opc_lui));
    pc_auipc = word_t'(wr_pos * 4);
    put(utype(20'h00010, 5'd2, opc_auipc));
    pc_jal = word_t'(wr_pos * 4);
    put(jtype(5'd3, 21'd12));
    save(5'd1, 9);
    save(5'd1, 9);
    save(5'd3, 2);
    put(itype(12'h030, 3'b000, 5'd5, 5'd0, opc_imm));
    pc_jalr = word_t'(wr_pos * 4);
    // Odd sum, bit 0 of the target must be cleared
    put(itype(12'd5, 3'b000, 5'd4, 5'd5, opc_jalr));
    save(5'd1, 9);
    save(5'd1, 9);
    jalr_target = (32'h30 + 32'd5) & ~32'd1;
    pad_to(jalr_target);
    save(5'd4, 3);
    save(5'd1, 0);
    save(5'd2, 1);
    run_program("jumps");
    expect_word("lui", 0, 32'h12345 << 12);
    expect_word("auipc", 1, pc_auipc + (32'h10 << 12));
    expect_word("jal link", 2, pc_jal + 32'd4);
    expect_word("jalr link", 3, pc_jalr + 32'd4);
    expect_word("jump shadow", 9, fill_word(slot_addr(9)));
  endtask

  task automatic x0_test();
    new_program();
    put(itype(12'd99, 3'b000, 5'd7, 5'd0, opc_imm));
    put(itype(12'd55, 3'b000, 5'd0, 5'd0, opc_imm));
    put(rtype(7'h00, 3'b000, 5'd0, 5'd7, 5'd7));
    put(rtype(7'h00, 3'b000, 5'd1, 5'd0, 5'd0));
    save(5'd0, 0);
    save(5'd1, 1);
    put(itype(12'h040, 3'b010, 5'd0, 5'd0, opc_load));
    put(rtype(7'h00, 3'b000, 5'd3, 5'd0, 5'd7));
    save(5'd3, 2);
    run_program("x0");
    expect_word("x0 store", 0, 32'd0);
    expect_word("x0 read", 1, 32'd0);
    expect_word("x0 after load", 2, 32'd0 + 32'd99);
  endtask

  task automatic random_alu_test();
    word_t a;
    word_t b;
    for (int n = 0; n < 20; n++) begin
      a = $random(seed);
      b = $random(seed);
      new_program();
      load_imm(5'd1, a);
      load_imm(5'd2, b);
      for (int k = 0; k < 10; k++) begin
        put(alu_instr(k));
        save(5'd10, k);
      end
      run_program("random_alu");
      for (int k = 0; k < 10; k++) begin
        expect_word($sformatf("random_alu pair %0d op %0d", n, k), k, alu_model(k, a, b));
      end
    end
  endtask

  initial begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    instr    = nop_instr;
    data_mem = '0;
    rd_word  = '0;
    done     = 1'b0;
    wr_pos   = 0;
    errors   = 0;
    checks   = 0;
    seed     = 32'h4a9f;
    forwarding_test();
    load_use_test();
    branches_test();
    jumps_test();
    x0_test();
    random_alu_test();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
